// ==== hdl/wb2sdrc_config.svh ====
//------------------------------
// bridge widths and fifo depths
// depths are powers of two and at least 4
//------------------------------
`ifndef WB2SDRC_CONFIG_SVH
`define WB2SDRC_CONFIG_SVH

//------------------------------
// data path
//------------------------------
// wishbone and controller data width
`define WB2SDRC_DW 32
// application word address width
`define WB2SDRC_AW 26

//------------------------------
// fifo depths
//------------------------------
// address plus read flag
`define WB2SDRC_CMD_DEPTH 4
// data plus byte enables
`define WB2SDRC_WR_DEPTH 8
// returning read data
`define WB2SDRC_RD_DEPTH 4

`endif

// ==== hdl/wb2sdrc_pkg.sv ====
//------------------------------
// types shared by the bridge blocks
// widths come from the config header
//------------------------------
`include "wb2sdrc_config.svh"

package wb2sdrc_pkg;

  //------------------------------
  // plain vectors
  //------------------------------
  // word address on both sides
  typedef logic [`WB2SDRC_AW-1:0] addr_t;

  // one data word
  typedef logic [`WB2SDRC_DW-1:0] data_t;

  // one bit per byte lane
  typedef logic [`WB2SDRC_DW/8-1:0] sel_t;

  //------------------------------
  // fifo entries
  //------------------------------
  // command entry
  // rd set means read, so it maps straight onto sdr_req_wr_n
  typedef struct packed {
    logic  rd;
    addr_t addr;
  } sdr_cmd_t;

  // write beat
  // en_n is the inverted wishbone select
  typedef struct packed {
    sel_t  en_n;
    data_t data;
  } wr_beat_t;

endpackage

// ==== hdl/async_fifo.sv ====
//------------------------------
// dual clock show-ahead fifo, DP a power of two and at least 4
// pushes while full and pops while empty are ignored
//------------------------------
`timescale 1ns/1ps

module async_fifo #(
  parameter int W  = 8,
  parameter int DP = 4
) (
  // write side
  input  logic         wr_clk_i,
  input  logic         wr_rst_i,
  input  logic         wr_en_i,
  input  logic [W-1:0] wr_data_i,
  output logic         full_o,
  // read side
  input  logic         rd_clk_i,
  input  logic         rd_rst_i,
  input  logic         rd_en_i,
  output logic [W-1:0] rd_data_o,
  output logic         empty_o
);

  localparam int AW = $clog2(DP);

  // index bits plus one wrap bit
  typedef logic [AW:0] ptr_t;

  // storage
  logic [W-1:0] mem [DP];

  // write domain
  ptr_t wr_bin;
  ptr_t wr_gray;
  ptr_t wr_bin_nxt;
  ptr_t wr_gray_nxt;
  ptr_t rd_gray_s1;
  ptr_t rd_gray_s2;
  logic wr_inc;
  logic full_nxt;

  // read domain
  ptr_t rd_bin;
  ptr_t rd_gray;
  ptr_t rd_bin_nxt;
  ptr_t rd_gray_nxt;
  ptr_t wr_gray_s1;
  ptr_t wr_gray_s2;
  logic rd_inc;

  //------------------------------
  // write domain
  //------------------------------
  // push only with room
  assign wr_inc      = wr_en_i & ~full_o;
  assign wr_bin_nxt  = wr_bin + ptr_t'(wr_inc);
  assign wr_gray_nxt = (wr_bin_nxt >> 1) ^ wr_bin_nxt;

  // full when next gray differs only in the top two bits
  assign full_nxt = (wr_gray_nxt == {~rd_gray_s2[AW:AW-1], rd_gray_s2[AW-2:0]});

  always_ff @(posedge wr_clk_i or posedge wr_rst_i) begin
    if (wr_rst_i) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      full_o  <= 1'b0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
      // registered full, lags a pop by the sync delay
      full_o  <= full_nxt;
    end
  end

  // read pointer into write clock
  always_ff @(posedge wr_clk_i or posedge wr_rst_i) begin
    if (wr_rst_i) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  // memory write, no reset on payload
  always_ff @(posedge wr_clk_i) begin
    if (wr_inc) begin
      mem[wr_bin[AW-1:0]] <= wr_data_i;
    end
  end

  //------------------------------
  // read domain
  //------------------------------
  // pop only with data
  assign rd_inc      = rd_en_i & ~empty_o;
  assign rd_bin_nxt  = rd_bin + ptr_t'(rd_inc);
  assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;

  always_ff @(posedge rd_clk_i or posedge rd_rst_i) begin
    if (rd_rst_i) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  // write pointer into read clock
  always_ff @(posedge rd_clk_i or posedge rd_rst_i) begin
    if (rd_rst_i) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  // empty once pointers match
  assign empty_o = (rd_gray == wr_gray_s2);

  // show-ahead head of queue
  assign rd_data_o = mem[rd_bin[AW-1:0]];

endmodule

// ==== hdl/wb_slave_ctrl.sv ====
//------------------------------
// single beat wishbone slave, classic cycles only
// one read in flight, acked when its data returns
//------------------------------
`timescale 1ns/1ps

module wb_slave_ctrl (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  // wishbone slave
  input  logic                  wb_stb_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_we_i,
  input  wb2sdrc_pkg::addr_t    wb_addr_i,
  input  wb2sdrc_pkg::data_t    wb_dat_i,
  input  wb2sdrc_pkg::sel_t     wb_sel_i,
  output logic                  wb_ack_o,
  // command fifo
  input  logic                  cmd_full_i,
  output logic                  cmd_push_o,
  output wb2sdrc_pkg::sdr_cmd_t cmd_o,
  // write data fifo
  input  logic                  wr_full_i,
  output logic                  wr_push_o,
  output wb2sdrc_pkg::wr_beat_t wr_beat_o,
  // read data fifo
  input  logic                  rd_empty_i,
  output logic                  rd_pop_o
);

  import wb2sdrc_pkg::*;

  logic wb_req;
  logic wr_req;
  logic rd_req;
  logic wr_room;
  logic rd_push;
  logic rd_ack;
  // read command sent, data not yet returned
  logic pending_read;

  //------------------------------
  // request decode
  //------------------------------
  assign wb_req = wb_stb_i & wb_cyc_i;
  assign wr_req = wb_req & wb_we_i;
  assign rd_req = wb_req & ~wb_we_i;

  // write needs room in both fifos
  assign wr_room = ~cmd_full_i & ~wr_full_i;

  // read goes out once
  assign rd_push = rd_req & ~cmd_full_i & ~pending_read;

  // read data waiting at the fifo head
  assign rd_ack = rd_req & ~rd_empty_i;

  //------------------------------
  // acknowledge and strobes
  //------------------------------
  // write acked in the same cycle
  assign wb_ack_o = (wr_req & wr_room) | rd_ack;

  assign cmd_push_o = (wr_req & wr_room) | rd_push;
  assign wr_push_o  = wr_req & wr_room;

  // head word leaves with the ack
  assign rd_pop_o = rd_ack;

  // fifo entries
  assign cmd_o.rd       = ~wb_we_i;
  assign cmd_o.addr     = wb_addr_i;
  assign wr_beat_o.en_n = ~wb_sel_i;
  assign wr_beat_o.data = wb_dat_i;

  //------------------------------
  // pending read
  //------------------------------
  // set on push, clear on ack
  // stops a second push of the same read
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      pending_read <= 1'b0;
    end else if (rd_push) begin
      pending_read <= 1'b1;
    end else if (rd_ack) begin
      pending_read <= 1'b0;
    end
  end

endmodule

// ==== hdl/wb2sdrc.sv ====
//------------------------------
// wishbone to sdram controller bridge, single beats only
// controller acks only while sdr_req_o is high
//------------------------------
`timescale 1ns/1ps
`include "wb2sdrc_config.svh"

module wb2sdrc (
  // wishbone side
  input  logic               wb_clk_i,
  input  logic               wb_rst_i,
  input  logic               wb_stb_i,
  input  logic               wb_cyc_i,
  // 1 write, 0 read
  input  logic               wb_we_i,
  input  wb2sdrc_pkg::addr_t wb_addr_i,
  input  wb2sdrc_pkg::data_t wb_dat_i,
  input  wb2sdrc_pkg::sel_t  wb_sel_i,
  output logic               wb_ack_o,
  output wb2sdrc_pkg::data_t wb_dat_o,
  // sdram controller side
  input  logic               sdram_clk_i,
  input  logic               sdram_rst_i,
  output logic               sdr_req_o,
  output wb2sdrc_pkg::addr_t sdr_req_addr_o,
  // 0 write, 1 read
  output logic               sdr_req_wr_n_o,
  input  logic               sdr_req_ack_i,
  // active low byte enables
  output wb2sdrc_pkg::sel_t  sdr_wr_en_n_o,
  output wb2sdrc_pkg::data_t sdr_wr_data_o,
  input  logic               sdr_wr_next_i,
  input  logic               sdr_rd_valid_i,
  input  wb2sdrc_pkg::data_t sdr_rd_data_i
);

  import wb2sdrc_pkg::*;

  // command path
  logic     cmd_push;
  logic     cmd_full;
  logic     cmd_empty;
  sdr_cmd_t cmd_in;
  sdr_cmd_t cmd_head;

  // write data path
  logic     wr_push;
  logic     wr_full;
  wr_beat_t wr_beat;
  wr_beat_t wr_head;

  // read data path
  logic     rd_pop;
  logic     rd_empty;

  //------------------------------
  // wishbone slave
  //------------------------------
  wb_slave_ctrl u_wb_slave_ctrl (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wb_stb_i   (wb_stb_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_we_i    (wb_we_i),
    .wb_addr_i  (wb_addr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_sel_i   (wb_sel_i),
    .wb_ack_o   (wb_ack_o),
    .cmd_full_i (cmd_full),
    .cmd_push_o (cmd_push),
    .cmd_o      (cmd_in),
    .wr_full_i  (wr_full),
    .wr_push_o  (wr_push),
    .wr_beat_o  (wr_beat),
    .rd_empty_i (rd_empty),
    .rd_pop_o   (rd_pop)
  );

  //------------------------------
  // command fifo, wb to sdram
  //------------------------------
  async_fifo #(.W($bits(sdr_cmd_t)), .DP(`WB2SDRC_CMD_DEPTH)) u_cmd_fifo (
    .wr_clk_i  (wb_clk_i),
    .wr_rst_i  (wb_rst_i),
    .wr_en_i   (cmd_push),
    .wr_data_i (cmd_in),
    .full_o    (cmd_full),
    .rd_clk_i  (sdram_clk_i),
    .rd_rst_i  (sdram_rst_i),
    // controller ack pops the command
    .rd_en_i   (sdr_req_ack_i),
    .rd_data_o (cmd_head),
    .empty_o   (cmd_empty)
  );

  // request level while a command waits
  assign sdr_req_o      = ~cmd_empty;
  assign sdr_req_addr_o = cmd_head.addr;
  assign sdr_req_wr_n_o = cmd_head.rd;

  //------------------------------
  // write data fifo, wb to sdram
  //------------------------------
  // controller paces pops per write command, so empty is unused
  async_fifo #(.W($bits(wr_beat_t)), .DP(`WB2SDRC_WR_DEPTH)) u_wr_fifo (
    .wr_clk_i  (wb_clk_i),
    .wr_rst_i  (wb_rst_i),
    .wr_en_i   (wr_push),
    .wr_data_i (wr_beat),
    .full_o    (wr_full),
    .rd_clk_i  (sdram_clk_i),
    .rd_rst_i  (sdram_rst_i),
    .rd_en_i   (sdr_wr_next_i),
    .rd_data_o (wr_head),
    .empty_o   ()
  );

  assign sdr_wr_en_n_o = wr_head.en_n;
  assign sdr_wr_data_o = wr_head.data;

  //------------------------------
  // read data fifo, sdram to wb
  //------------------------------
  // one read in flight, full never reached
  async_fifo #(.W($bits(data_t)), .DP(`WB2SDRC_RD_DEPTH)) u_rd_fifo (
    .wr_clk_i  (sdram_clk_i),
    .wr_rst_i  (sdram_rst_i),
    .wr_en_i   (sdr_rd_valid_i),
    .wr_data_i (sdr_rd_data_i),
    .full_o    (),
    .rd_clk_i  (wb_clk_i),
    .rd_rst_i  (wb_rst_i),
    .rd_en_i   (rd_pop),
    .rd_data_o (wb_dat_o),
    .empty_o   (rd_empty)
  );

endmodule

// ==== tests/sdram_ctrl_model.sv ====
//------------------------------
// behavioral sdram controller, 64 words, address wraps at 64
// takes one command every two clocks, stall_i holds off the ack
//------------------------------
`timescale 1ns/1ps

module sdram_ctrl_model (
  input  logic               sdram_clk_i,
  input  logic               sdram_rst_i,
  input  logic               stall_i,
  // request side
  input  logic               sdr_req_i,
  input  wb2sdrc_pkg::addr_t sdr_req_addr_i,
  input  logic               sdr_req_wr_n_i,
  output logic               sdr_req_ack_o,
  // write data
  input  wb2sdrc_pkg::sel_t  sdr_wr_en_n_i,
  input  wb2sdrc_pkg::data_t sdr_wr_data_i,
  output logic               sdr_wr_next_o,
  // read data
  output logic               sdr_rd_valid_o,
  output wb2sdrc_pkg::data_t sdr_rd_data_o
);

  import wb2sdrc_pkg::*;

  localparam int LANES = $bits(sel_t);

  // word storage, starts at zero
  data_t      mem [64];
  logic [5:0] idx;
  logic       take;

  assign idx = sdr_req_addr_i[5:0];

  // new request only, the one just acked is still at the head
  assign take = sdr_req_i & ~sdr_req_ack_o & ~stall_i;

  always_ff @(posedge sdram_clk_i or posedge sdram_rst_i) begin
    if (sdram_rst_i) begin
      sdr_req_ack_o  <= 1'b0;
      sdr_wr_next_o  <= 1'b0;
      sdr_rd_valid_o <= 1'b0;
      sdr_rd_data_o  <= '0;
      for (int i = 0; i < 64; i++) begin
        mem[i] <= '0;
      end
    end else begin
      // single cycle pulses
      sdr_req_ack_o  <= 1'b0;
      sdr_wr_next_o  <= 1'b0;
      sdr_rd_valid_o <= 1'b0;
      if (take) begin
        sdr_req_ack_o <= 1'b1;
        if (sdr_req_wr_n_i) begin
          sdr_rd_valid_o <= 1'b1;
          sdr_rd_data_o  <= mem[idx];
        end else begin
          sdr_wr_next_o <= 1'b1;
          // write fifo head belongs to this command
          for (int b = 0; b < LANES; b++) begin
            if (!sdr_wr_en_n_i[b]) begin
              mem[idx][8*b +: 8] <= sdr_wr_data_i[8*b +: 8];
            end
          end
        end
      end
    end
  end

endmodule

// ==== tests/tb_wb2sdrc.sv ====
//------------------------------
// bridge testbench, operations come from tests/wb2sdrc_testdata.txt
// run from the project root, stops at the first mismatch
//------------------------------
`timescale 1ns/1ps

module tb_wb2sdrc;

  import wb2sdrc_pkg::*;

  localparam int MAX_OPS = 64;

  // wishbone side
  logic  wb_clk_i;
  logic  wb_rst_i;
  logic  wb_stb_i;
  logic  wb_cyc_i;
  logic  wb_we_i;
  addr_t wb_addr_i;
  data_t wb_dat_i;
  sel_t  wb_sel_i;
  logic  wb_ack_o;
  data_t wb_dat_o;

  // controller side
  logic  sdram_clk_i;
  logic  sdram_rst_i;
  logic  sdr_req_o;
  addr_t sdr_req_addr_o;
  logic  sdr_req_wr_n_o;
  logic  sdr_req_ack_i;
  sel_t  sdr_wr_en_n_o;
  data_t sdr_wr_data_o;
  logic  sdr_wr_next_i;
  logic  sdr_rd_valid_i;
  data_t sdr_rd_data_i;
  logic  stall_i;

  // operations from the data file
  byte         op_mem   [MAX_OPS];
  logic [31:0] addr_mem [MAX_OPS];
  logic [31:0] data_mem [MAX_OPS];
  logic [31:0] sel_mem  [MAX_OPS];
  logic [31:0] exp_mem  [MAX_OPS];
  int          num_ops = 0;

  // run limit
  int cycle_count = 0;
  int cycle_limit = 1000;

  // stall window bookkeeping
  int stall_left   = 0;
  int stall_acks   = 0;
  int stall_expect = 0;

  wb2sdrc u_wb2sdrc (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .wb_stb_i       (wb_stb_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_we_i        (wb_we_i),
    .wb_addr_i      (wb_addr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_sel_i       (wb_sel_i),
    .wb_ack_o       (wb_ack_o),
    .wb_dat_o       (wb_dat_o),
    .sdram_clk_i    (sdram_clk_i),
    .sdram_rst_i    (sdram_rst_i),
    .sdr_req_o      (sdr_req_o),
    .sdr_req_addr_o (sdr_req_addr_o),
    .sdr_req_wr_n_o (sdr_req_wr_n_o),
    .sdr_req_ack_i  (sdr_req_ack_i),
    .sdr_wr_en_n_o  (sdr_wr_en_n_o),
    .sdr_wr_data_o  (sdr_wr_data_o),
    .sdr_wr_next_i  (sdr_wr_next_i),
    .sdr_rd_valid_i (sdr_rd_valid_i),
    .sdr_rd_data_i  (sdr_rd_data_i)
  );

  sdram_ctrl_model u_sdram_ctrl_model (
    .sdram_clk_i    (sdram_clk_i),
    .sdram_rst_i    (sdram_rst_i),
    .stall_i        (stall_i),
    .sdr_req_i      (sdr_req_o),
    .sdr_req_addr_i (sdr_req_addr_o),
    .sdr_req_wr_n_i (sdr_req_wr_n_o),
    .sdr_req_ack_o  (sdr_req_ack_i),
    .sdr_wr_en_n_i  (sdr_wr_en_n_o),
    .sdr_wr_data_i  (sdr_wr_data_o),
    .sdr_wr_next_o  (sdr_wr_next_i),
    .sdr_rd_valid_o (sdr_rd_valid_i),
    .sdr_rd_data_o  (sdr_rd_data_i)
  );

  //------------------------------
  // clocks
  //------------------------------
  initial begin
    wb_clk_i = 1'b0;
    forever #50 wb_clk_i = ~wb_clk_i;
  end

  // offset keeps sdram edges off the wb edges and drive points
  initial begin
    sdram_clk_i = 1'b0;
    #3;
    forever #35 sdram_clk_i = ~sdram_clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error: %s is 0x%h, expected 0x%h", name, actual, expected);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic load_testdata();
    int               fd;
    int               code;
    byte              op;
    logic [31:0]      a;
    logic [31:0]      d;
    logic [31:0]      s;
    logic [31:0]      e;
    logic [8*128-1:0] rest;
    fd = $fopen("tests/wb2sdrc_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/wb2sdrc_testdata.txt");
      $display("Test failures found");
      $fatal(1, "no test data");
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, " %c", op);
        if (code == 1 && op == "#") begin
          // comment line, drop the rest of it
          code = $fgets(rest, fd);
        end else if (code == 1) begin
          code = $fscanf(fd, "%h %h %h %h", a, d, s, e);
          if (code != 4 || num_ops == MAX_OPS) begin
            $display("test data line %0d is malformed or beyond the table", num_ops + 1);
            $display("Test failures found");
            $fatal(1, "bad test data");
          end else begin
            op_mem[num_ops]   = op;
            addr_mem[num_ops] = a;
            data_mem[num_ops] = d;
            sel_mem[num_ops]  = s;
            exp_mem[num_ops]  = e;
            num_ops++;
          end
        end
      end
      $fclose(fd);
      // 200 cycles per operation plus reset
      cycle_limit = 200 * num_ops + 20;
    end
  endtask

  //------------------------------
  // wishbone driver
  //------------------------------
  // ack sampled mid cycle, transfer happens at the next rising edge
  task automatic wait_for_ack();
    @(negedge wb_clk_i);
    while (!wb_ack_o) begin
      @(negedge wb_clk_i);
    end
  endtask

  task automatic write_word(input logic [31:0] a, input logic [31:0] d,
                            input logic [31:0] s);
    #5;
    wb_stb_i  = 1'b1;
    wb_cyc_i  = 1'b1;
    wb_we_i   = 1'b1;
    wb_addr_i = addr_t'(a);
    wb_dat_i  = data_t'(d);
    wb_sel_i  = sel_t'(s);
    wait_for_ack();
    @(posedge wb_clk_i);
  endtask

  task automatic read_word(input logic [31:0] a, input logic [31:0] e);
    #5;
    wb_stb_i  = 1'b1;
    wb_cyc_i  = 1'b1;
    wb_we_i   = 1'b0;
    wb_addr_i = addr_t'(a);
    wb_dat_i  = '0;
    wb_sel_i  = '1;
    wait_for_ack();
    check_value("wb_dat_o", wb_dat_o, e);
    @(posedge wb_clk_i);
  endtask

  // bus idle, controller stalled for len cycles
  task automatic stall_model(input logic [31:0] len, input logic [31:0] acks);
    #5;
    wb_stb_i     = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_we_i      = 1'b0;
    stall_i      = 1'b1;
    stall_acks   = 0;
    stall_expect = acks;
    stall_left   = len;
    @(posedge wb_clk_i);
  endtask

  // count write acks while stalled, command fifo depth bounds them
  always @(negedge wb_clk_i) begin
    if (stall_left > 0) begin
      if (wb_ack_o && wb_we_i) begin
        stall_acks++;
      end
      stall_left--;
      if (stall_left == 0) begin
        check_value("write acks while stalled", stall_acks, stall_expect);
        stall_i = 1'b0;
      end
    end
  end

  //------------------------------
  // timeout
  //------------------------------
  always @(posedge wb_clk_i) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run went past %0d wb_clk_i cycles", cycle_limit);
      $display("Test failures found");
      $fatal(1, "stopped by timeout");
    end
  end

  //------------------------------
  // main sequence
  //------------------------------
  initial begin
    wb_rst_i    = 1'b1;
    sdram_rst_i = 1'b1;
    wb_stb_i    = 1'b0;
    wb_cyc_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_addr_i   = '0;
    wb_dat_i    = '0;
    wb_sel_i    = '0;
    stall_i     = 1'b0;
    load_testdata();

    repeat (10) @(posedge wb_clk_i);
    #5;
    wb_rst_i    = 1'b0;
    sdram_rst_i = 1'b0;

    // idle after reset
    repeat (4) @(negedge wb_clk_i);
    check_value("wb_ack_o", wb_ack_o, 32'h0);
    check_value("sdr_req_o", sdr_req_o, 32'h0);
    @(posedge wb_clk_i);

    for (int i = 0; i < num_ops; i++) begin
      case (op_mem[i])
        "W": write_word(addr_mem[i], data_mem[i], sel_mem[i]);
        "R": read_word(addr_mem[i], exp_mem[i]);
        "S": stall_model(data_mem[i], exp_mem[i]);
        default: begin
          $display("unknown op code on test data line %0d", i + 1);
          $display("Test failures found");
          $fatal(1, "bad op code");
        end
      endcase
    end

    #5;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
    repeat (4) @(posedge wb_clk_i);
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== wb2sdrc.f ====
+incdir+hdl
hdl/wb2sdrc_pkg.sv
hdl/async_fifo.sv
hdl/wb_slave_ctrl.sv
hdl/wb2sdrc.sv
tests/sdram_ctrl_model.sv
tests/tb_wb2sdrc.sv

// ==== tests/wb2sdrc_testdata.txt ====
# op addr data sel expect, fields after the op in hex; W write, R read and compare
# S stalls the controller: data is the length in wb cycles, expect the writes acked meanwhile
W 00000001 11223344 f 00000000
W 00000002 cafef00d f 00000000
R 00000003 00000000 0 00000000
R 00000001 00000000 0 11223344
R 00000002 00000000 0 cafef00d
W 00000001 aabbccdd 5 00000000
R 00000001 00000000 0 11bb33dd
W 00000002 00000000 c 00000000
R 00000002 00000000 0 0000f00d
W 00000005 0badc0de 2 00000000
R 00000005 00000000 0 0000c000
S 00000000 00000028 0 00000004
W 00000010 10101010 f 00000000
W 00000011 21212121 f 00000000
W 00000012 32323232 f 00000000
W 00000013 43434343 f 00000000
W 00000014 54545454 f 00000000
R 00000010 00000000 0 10101010
R 00000011 00000000 0 21212121
R 00000012 00000000 0 32323232
R 00000013 00000000 0 43434343
R 00000014 00000000 0 54545454
